// ==== design/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// instruction memory, in words
`define CPU_IMEM_AW 6
`define CPU_IMEM_DEPTH 64

// data memory, in words
`define CPU_DMEM_AW 6
`define CPU_DMEM_DEPTH 64

`endif

// ==== design/isa_pkg.sv ====
package isa_pkg;

	// major opcode, instruction bits 30:25
	typedef enum logic [5:0] {
		op_ty_base = 6'b100000,
		op_addi    = 6'b101000,
		op_ori     = 6'b101100,
		op_xori    = 6'b101011,
		op_movi    = 6'b100010,
		op_lwi     = 6'b000010,
		op_swi     = 6'b001010,
		op_ty_ls   = 6'b011100
	} opcode_e;

	// ty_base sub-opcode, bits 4:0
	typedef enum logic [4:0] {
		sub_add   = 5'b00000,
		sub_sub   = 5'b00001,
		sub_and   = 5'b00010,
		sub_xor   = 5'b00011,
		sub_or    = 5'b00100,
		sub_slli  = 5'b01000,
		sub_srli  = 5'b01001,
		sub_rotri = 5'b01011
	} base_subop_e;

	// ty_ls sub-opcode, bits 7:0
	typedef enum logic [7:0] {
		ls_lw = 8'b00000010,
		ls_sw = 8'b00001010
	} ls_subop_e;

	typedef struct packed {
		opcode_e     opcode;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [4:0]  rb;
		base_subop_e base_subop;
		ls_subop_e   ls_subop;
		logic [1:0]  sv;
		logic [4:0]  imm5;
		logic [14:0] imm15;
		logic [19:0] imm20;
	} instr_fields_t;

endpackage

// ==== design/ctrl_pkg.sv ====
`include "cpu_defines.svh"

package ctrl_pkg;

	typedef enum logic [2:0] {
		ph_fetch,
		ph_decode,
		ph_execute,
		ph_memaccess,
		ph_writeback
	} phase_e;

	typedef enum logic [1:0] {
		opnd_reg_reg,
		opnd_reg_imm,
		opnd_base_imm,
		opnd_base_index
	} operand_sel_e;

	typedef enum logic [1:0] {
		ext_zero5,
		ext_sign15,
		ext_zero15,
		ext_sign20
	} extend_sel_e;

	typedef enum logic [1:0] {
		wb_alu,
		wb_imm,
		wb_mem
	} wb_sel_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_srl,
		alu_sll,
		alu_rotr,
		alu_pass_b
	} alu_op_e;

	typedef struct packed {
		operand_sel_e operand_sel;
		extend_sel_e  extend_sel;
		wb_sel_e      wb_sel;
		alu_op_e      alu_op;
		logic         dm_read;
		logic         dm_write;
		logic         reg_write;
	} ctrl_t;

	typedef struct packed {
		logic fetch;
		logic decode;
		logic execute;
		logic memaccess;
		logic writeback;
	} phase_strobes_t;

	typedef struct packed {
		logic                    we;
		logic [`CPU_IMEM_AW-1:0] addr;
		logic [31:0]             data;
	} imem_load_t;

	typedef struct packed {
		logic        valid;
		logic [4:0]  addr;
		logic [31:0] data;
	} retire_t;

	typedef struct packed {
		logic                    valid;
		logic [`CPU_DMEM_AW-1:0] addr;
		logic [31:0]             data;
	} store_t;

endpackage

// ==== design/controller.sv ====
`timescale 1ns/100ps

module controller import isa_pkg::*, ctrl_pkg::*; (
	input  logic           clock,
	input  logic           reset,
	input  logic [31:0]    instr,
	output phase_strobes_t strobes,
	output instr_fields_t  fields,
	output ctrl_t          ctrl
);

	localparam ctrl_t nop_ctrl = '{
		operand_sel: opnd_reg_reg,
		extend_sel:  ext_zero5,
		wb_sel:      wb_alu,
		alu_op:      alu_add,
		dm_read:     1'b0,
		dm_write:    1'b0,
		reg_write:   1'b0
	};

	phase_e phase;
	phase_e phase_next;
	ctrl_t  ctrl_dec;

	// instruction slices, stable from decode until the next fetch
	always_comb begin
		fields.opcode     = opcode_e'(instr[30:25]);
		fields.rt         = instr[24:20];
		fields.ra         = instr[19:15];
		fields.rb         = instr[14:10];
		fields.base_subop = base_subop_e'(instr[4:0]);
		fields.ls_subop   = ls_subop_e'(instr[7:0]);
		fields.sv         = instr[9:8];
		fields.imm5       = instr[14:10];
		fields.imm15      = instr[14:0];
		fields.imm20      = instr[19:0];
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			phase <= ph_fetch;
		end else begin
			phase <= phase_next;
		end
	end

	always_comb begin
		strobes = '0;
		phase_next = ph_fetch;
		case (phase)
			ph_fetch: begin
				strobes.fetch = 1'b1;
				phase_next = ph_decode;
			end
			ph_decode: begin
				strobes.decode = 1'b1;
				phase_next = ph_execute;
			end
			ph_execute: begin
				strobes.execute = 1'b1;
				phase_next = ph_memaccess;
			end
			ph_memaccess: begin
				strobes.memaccess = 1'b1;
				phase_next = ph_writeback;
			end
			ph_writeback: begin
				strobes.writeback = 1'b1;
			end
			default: begin
				phase_next = ph_fetch;
			end
		endcase
	end

	// decoder, undefined codes fall through to nop
	always_comb begin
		ctrl_dec = nop_ctrl;
		case (fields.opcode)
			op_ty_base: begin
				ctrl_dec.reg_write = 1'b1;
				case (fields.base_subop)
					sub_add: ctrl_dec.alu_op = alu_add;
					sub_sub: ctrl_dec.alu_op = alu_sub;
					sub_and: ctrl_dec.alu_op = alu_and;
					sub_or:  ctrl_dec.alu_op = alu_or;
					sub_xor: ctrl_dec.alu_op = alu_xor;
					sub_srli: begin
						ctrl_dec.operand_sel = opnd_reg_imm;
						ctrl_dec.alu_op = alu_srl;
					end
					sub_slli: begin
						ctrl_dec.operand_sel = opnd_reg_imm;
						ctrl_dec.alu_op = alu_sll;
					end
					sub_rotri: begin
						ctrl_dec.operand_sel = opnd_reg_imm;
						ctrl_dec.alu_op = alu_rotr;
					end
					default: ctrl_dec.reg_write = 1'b0;
				endcase
			end
			op_addi, op_ori, op_xori: begin
				ctrl_dec.operand_sel = opnd_reg_imm;
				ctrl_dec.reg_write = 1'b1;
				if (fields.opcode == op_addi) begin
					ctrl_dec.extend_sel = ext_sign15;
					ctrl_dec.alu_op = alu_add;
				end else begin
					ctrl_dec.extend_sel = ext_zero15;
					ctrl_dec.alu_op = (fields.opcode == op_ori) ? alu_or : alu_xor;
				end
			end
			op_movi: begin
				ctrl_dec.operand_sel = opnd_reg_imm;
				ctrl_dec.extend_sel = ext_sign20;
				ctrl_dec.alu_op = alu_pass_b;
				ctrl_dec.wb_sel = wb_imm;
				ctrl_dec.reg_write = 1'b1;
			end
			op_lwi, op_swi: begin
				ctrl_dec.operand_sel = opnd_base_imm;
				ctrl_dec.extend_sel = ext_zero15;
				ctrl_dec.wb_sel = wb_mem;
				ctrl_dec.dm_read = (fields.opcode == op_lwi);
				ctrl_dec.dm_write = (fields.opcode == op_swi);
				ctrl_dec.reg_write = (fields.opcode == op_lwi);
			end
			op_ty_ls: begin
				ctrl_dec.operand_sel = opnd_base_index;
				ctrl_dec.wb_sel = wb_mem;
				ctrl_dec.dm_read = (fields.ls_subop == ls_lw);
				ctrl_dec.dm_write = (fields.ls_subop == ls_sw);
				ctrl_dec.reg_write = (fields.ls_subop == ls_lw);
			end
			default: ctrl_dec = nop_ctrl;
		endcase
	end

	// held from end of decode through writeback
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			ctrl <= nop_ctrl;
		end else if (strobes.decode) begin
			ctrl <= ctrl_dec;
		end
	end

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module fetch_unit import ctrl_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        fetch,
	input  imem_load_t  load,
	output logic [31:0] instr
);

	logic [`CPU_IMEM_AW-1:0] pc;
	logic [31:0]             imem [`CPU_IMEM_DEPTH];

	// program load only while the core is held in reset
	always_ff @(posedge clock) begin
		if (reset && load.we) begin
			imem[load.addr] <= load.data;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (fetch) begin
			pc <= pc + 1'b1;
		end
	end

	// instruction register
	always_ff @(posedge clock) begin
		if (fetch) begin
			instr <= imem[pc];
		end
	end

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/100ps

module register_file (
	input  logic        clock,
	input  logic        reset,
	input  logic [4:0]  ra_addr,
	input  logic [4:0]  rb_addr,
	input  logic [4:0]  rt_addr,
	input  logic        we,
	input  logic [31:0] wdata,
	output logic [31:0] ra_data,
	output logic [31:0] rb_data,
	output logic [31:0] rt_data
);

	logic [31:0] regs [32];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rt_addr != 5'd0) begin
			regs[rt_addr] <= wdata;
		end
	end

	// r0 hardwired to zero
	assign ra_data = (ra_addr == 5'd0) ? 32'd0 : regs[ra_addr];
	assign rb_data = (rb_addr == 5'd0) ? 32'd0 : regs[rb_addr];
	assign rt_data = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];

endmodule

// ==== design/execute_unit.sv ====
`timescale 1ns/100ps

module execute_unit import isa_pkg::*, ctrl_pkg::*; (
	input  logic          clock,
	input  logic          reset,
	input  logic          execute,
	input  ctrl_t         ctrl,
	input  instr_fields_t fields,
	input  logic [31:0]   ra_data,
	input  logic [31:0]   rb_data,
	output logic [31:0]   result
);

	logic [31:0] imm_ext;
	logic [31:0] op_b;
	logic [63:0] rot_src;
	logic [31:0] alu_out;

	always_comb begin
		case (ctrl.extend_sel)
			ext_zero5:  imm_ext = {27'd0, fields.imm5};
			ext_sign15: imm_ext = {{17{fields.imm15[14]}}, fields.imm15};
			ext_zero15: imm_ext = {17'd0, fields.imm15};
			ext_sign20: imm_ext = {{12{fields.imm20[19]}}, fields.imm20};
			default:    imm_ext = 32'd0;
		endcase
	end

	always_comb begin
		case (ctrl.operand_sel)
			opnd_reg_reg:    op_b = rb_data;
			opnd_reg_imm:    op_b = imm_ext;
			opnd_base_imm:   op_b = {17'd0, fields.imm15};
			opnd_base_index: op_b = rb_data << fields.sv;
			default:         op_b = rb_data;
		endcase
	end

	// low half of the doubled word gives rotate right
	assign rot_src = {ra_data, ra_data} >> op_b[4:0];

	always_comb begin
		case (ctrl.alu_op)
			alu_add:    alu_out = ra_data + op_b;
			alu_sub:    alu_out = ra_data - op_b;
			alu_and:    alu_out = ra_data & op_b;
			alu_or:     alu_out = ra_data | op_b;
			alu_xor:    alu_out = ra_data ^ op_b;
			alu_srl:    alu_out = ra_data >> op_b[4:0];
			alu_sll:    alu_out = ra_data << op_b[4:0];
			alu_rotr:   alu_out = rot_src[31:0];
			alu_pass_b: alu_out = op_b;
			default:    alu_out = 32'd0;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			result <= '0;
		end else if (execute) begin
			result <= alu_out;
		end
	end

endmodule

// ==== design/data_mem.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module data_mem import ctrl_pkg::*; (
	input  logic                    clock,
	input  logic                    memaccess,
	input  ctrl_t                   ctrl,
	input  logic [`CPU_DMEM_AW-1:0] addr,
	input  logic [31:0]             wdata,
	output logic [31:0]             rdata
);

	logic [31:0] mem [`CPU_DMEM_DEPTH];

	always_ff @(posedge clock) begin
		if (memaccess && ctrl.dm_write) begin
			mem[addr] <= wdata;
		end
		if (memaccess && ctrl.dm_read) begin
			rdata <= mem[addr];
		end
	end

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_top import isa_pkg::*, ctrl_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  imem_load_t imem_load,
	output retire_t    retire,
	output store_t     store
);

	phase_strobes_t strobes;
	instr_fields_t  fields;
	ctrl_t          ctrl;
	logic [31:0]    instr;
	logic [31:0]    ra_data;
	logic [31:0]    rb_data;
	logic [31:0]    rt_data;
	logic [31:0]    result;
	logic [31:0]    mem_rdata;
	logic [31:0]    wb_data;
	logic           rf_we;

	controller u_controller (
		.clock   (clock),
		.reset   (reset),
		.instr   (instr),
		.strobes (strobes),
		.fields  (fields),
		.ctrl    (ctrl)
	);

	fetch_unit u_fetch (
		.clock (clock),
		.reset (reset),
		.fetch (strobes.fetch),
		.load  (imem_load),
		.instr (instr)
	);

	register_file u_regs (
		.clock   (clock),
		.reset   (reset),
		.ra_addr (fields.ra),
		.rb_addr (fields.rb),
		.rt_addr (fields.rt),
		.we      (rf_we),
		.wdata   (wb_data),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.rt_data (rt_data)
	);

	execute_unit u_execute (
		.clock   (clock),
		.reset   (reset),
		.execute (strobes.execute),
		.ctrl    (ctrl),
		.fields  (fields),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.result  (result)
	);

	// word address from the low bits of the sum
	data_mem u_dmem (
		.clock     (clock),
		.memaccess (strobes.memaccess),
		.ctrl      (ctrl),
		.addr      (result[`CPU_DMEM_AW-1:0]),
		.wdata     (rt_data),
		.rdata     (mem_rdata)
	);

	always_comb begin
		case (ctrl.wb_sel)
			wb_alu:  wb_data = result;
			wb_imm:  wb_data = {{12{fields.imm20[19]}}, fields.imm20};
			wb_mem:  wb_data = mem_rdata;
			default: wb_data = result;
		endcase
	end

	assign rf_we = strobes.writeback && ctrl.reg_write;

	// observation ports
	assign retire.valid = rf_we && (fields.rt != 5'd0);
	assign retire.addr  = fields.rt;
	assign retire.data  = wb_data;

	assign store.valid = strobes.memaccess && ctrl.dm_write;
	assign store.addr  = result[`CPU_DMEM_AW-1:0];
	assign store.data  = rt_data;

endmodule

// ==== sim/cpu_asserts.sv ====
`timescale 1ns/100ps

module cpu_asserts_m import ctrl_pkg::*; (
	input logic           clock,
	input logic           reset,
	input phase_strobes_t strobes,
	input ctrl_t          ctrl,
	input retire_t        retire,
	input store_t         store
);

	int fail_count = 0;

	logic [2:0] slot_cycle;

	// position within the five-cycle instruction slot
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			slot_cycle <= '0;
		end else if (slot_cycle == 3'd4) begin
			slot_cycle <= '0;
		end else begin
			slot_cycle <= slot_cycle + 1'b1;
		end
	end

	one_strobe: assert property (@(posedge clock) disable iff (reset) $onehot(strobes))
		else begin
			fail_count++;
			$error("phase strobes are not one-hot");
		end

	// full five-phase walk from every fetch
	phase_order: assert property (@(posedge clock) disable iff (reset)
		strobes.fetch |=> strobes.decode ##1 strobes.execute ##1 strobes.memaccess
		##1 strobes.writeback ##1 strobes.fetch)
		else begin
			fail_count++;
			$error("phases left the fixed order");
		end

	fetch_after_reset: assert property (@(posedge clock) $fell(reset) |-> strobes.fetch)
		else begin
			fail_count++;
			$error("first phase after reset is not fetch");
		end

	retire_in_writeback: assert property (@(posedge clock) disable iff (reset)
		retire.valid |-> slot_cycle == 3'd4)
		else begin
			fail_count++;
			$error("retire valid outside writeback");
		end

	store_in_memaccess: assert property (@(posedge clock) disable iff (reset)
		store.valid |-> slot_cycle == 3'd3)
		else begin
			fail_count++;
			$error("store valid outside memaccess");
		end

	no_read_and_write: assert property (@(posedge clock) disable iff (reset)
		!(ctrl.dm_read && ctrl.dm_write))
		else begin
			fail_count++;
			$error("data memory read and write set together");
		end

endmodule

// ==== sim/cpu_tb.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_tb import isa_pkg::*, ctrl_pkg::*;;

	localparam int clock_period = 40;
	localparam int seed_count = 8;
	localparam int fill_count = 16;
	localparam int mix_count = 24;
	localparam int kind_count = 20;
	localparam int prog_len = seed_count + fill_count + mix_count;
	localparam int reset_cycles = `CPU_IMEM_DEPTH + 10;
	localparam int watchdog_cycles = prog_len * 5 + reset_cycles + 20;

	logic       clock;
	logic       reset;
	imem_load_t imem_load;
	retire_t    retire;
	store_t     store;

	logic [31:0] prog [`CPU_IMEM_DEPTH];
	string       prog_name [`CPU_IMEM_DEPTH];
	logic [31:0] model_regs [32];
	logic [31:0] model_mem [`CPU_DMEM_DEPTH];
	int          check_count = 0;
	int          error_count = 0;

	string kind_names [kind_count] = '{
		"add", "sub", "and", "or", "xor", "srli", "slli", "rotri", "addi", "ori",
		"xori", "movi", "lwi", "swi", "lw", "sw", "undef_base", "undef_ls",
		"r0_write", "r0_read"
	};
	base_subop_e alu_subs [8] = '{
		sub_add, sub_sub, sub_and, sub_or, sub_xor, sub_srli, sub_slli, sub_rotri
	};
	opcode_e imm_ops [3] = '{op_addi, op_ori, op_xori};

	cpu_top uut (
		.clock     (clock),
		.reset     (reset),
		.imem_load (imem_load),
		.retire    (retire),
		.store     (store)
	);

	bind cpu_top cpu_asserts_m u_asserts (
		.clock   (clock),
		.reset   (reset),
		.strobes (strobes),
		.ctrl    (ctrl),
		.retire  (retire),
		.store   (store)
	);

	always #(clock_period / 2) clock = ~clock;

	function automatic logic [31:0] enc_r(input opcode_e op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [4:0] rb, input logic [9:0] low);
		return {1'b0, op, rt, ra, rb, low};
	endfunction

	function automatic logic [31:0] enc_i(input opcode_e op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [14:0] imm);
		return {1'b0, op, rt, ra, imm};
	endfunction

	// r1, r2 are bases and r3 the index, so rt is drawn from r4 up
	function automatic logic [31:0] random_instr(input int k);
		logic [4:0]  dst;
		logic [4:0]  src_a;
		logic [4:0]  src_b;
		logic [4:0]  base;
		logic [1:0]  sv;
		logic [19:0] imm;
		logic [31:0] word;
		dst = 5'(4 + $urandom_range(11));
		src_a = 5'($urandom_range(15));
		src_b = 5'($urandom_range(15));
		base = ($urandom_range(1) == 0) ? 5'd1 : 5'd2;
		sv = 2'($urandom_range(3));
		imm = 20'($urandom);
		if (k < 5) begin
			word = enc_r(op_ty_base, dst, src_a, src_b, {5'd0, alu_subs[k]});
		end else if (k < 8) begin
			word = enc_r(op_ty_base, dst, src_a, imm[4:0], {5'd0, alu_subs[k]});
		end else if (k < 11) begin
			word = enc_i(imm_ops[k - 8], dst, src_a, imm[14:0]);
		end else begin
			case (k)
				11: word = enc_i(op_movi, dst, imm[19:15], imm[14:0]);
				12: word = enc_i(op_lwi, dst, base, 15'($urandom_range(11)));
				13: word = enc_i(op_swi, src_a, base, 15'($urandom_range(11)));
				14: word = enc_r(op_ty_ls, dst, base, 5'd3, {sv, ls_lw});
				15: word = enc_r(op_ty_ls, src_a, base, 5'd3, {sv, ls_sw});
				// undefined sub-opcodes
				16: word = enc_r(op_ty_base, dst, src_a, src_b, 10'h01f);
				17: word = enc_r(op_ty_ls, dst, base, 5'd3, 10'h0ff);
				18: word = enc_i(op_addi, 5'd0, src_a, imm[14:0]);
				default: word = enc_r(op_ty_base, dst, 5'd0, src_b, {5'd0, sub_add});
			endcase
		end
		return word;
	endfunction

	task automatic build_program();
		logic [19:0] imm;
		int          k;
		// bases r1 = 0, r2 = 4, index r3 = 1 keep addresses below 16
		for (int r = 1; r <= seed_count; r++) begin
			imm = (r == 1) ? 20'd0 : (r == 2) ? 20'd4 : (r == 3) ? 20'd1 : 20'($urandom);
			prog[r - 1] = enc_i(op_movi, 5'(r), imm[19:15], imm[14:0]);
			prog_name[r - 1] = "movi";
		end
		// every reachable data word written before any load
		for (int i = 0; i < fill_count; i++) begin
			prog[seed_count + i] = enc_i(op_swi, 5'(4 + $urandom_range(4)), 5'd1, 15'(i));
			prog_name[seed_count + i] = "swi";
		end
		for (int i = 0; i < mix_count; i++) begin
			k = (i < kind_count) ? i : int'($urandom_range(kind_count - 1));
			prog[seed_count + fill_count + i] = random_instr(k);
			prog_name[seed_count + fill_count + i] = kind_names[k];
		end
	endtask

	// instruction-set model, one instruction per call
	function automatic void model_step(input logic [31:0] w, output retire_t ret,
			output store_t st);
		logic [4:0]  rt;
		logic [4:0]  sh;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] zext15;
		logic [31:0] val;
		logic [31:0] sum;
		logic        wr;
		logic        ld;
		logic        sto;
		rt = w[24:20];
		sh = w[14:10];
		a = model_regs[w[19:15]];
		b = model_regs[w[14:10]];
		zext15 = {17'd0, w[14:0]};
		val = 32'd0;
		sum = a + zext15;
		wr = 1'b0;
		ld = 1'b0;
		sto = 1'b0;
		ret = '0;
		st = '0;
		case (w[30:25])
			op_ty_base: begin
				wr = 1'b1;
				case (w[4:0])
					sub_add:   val = a + b;
					sub_sub:   val = a - b;
					sub_and:   val = a & b;
					sub_or:    val = a | b;
					sub_xor:   val = a ^ b;
					sub_srli:  val = a >> sh;
					sub_slli:  val = a << sh;
					sub_rotri: val = (a >> sh) | (a << (32 - sh));
					default:   wr = 1'b0;
				endcase
			end
			op_addi: begin
				val = a + {{17{w[14]}}, w[14:0]};
				wr = 1'b1;
			end
			op_ori: begin
				val = a | zext15;
				wr = 1'b1;
			end
			op_xori: begin
				val = a ^ zext15;
				wr = 1'b1;
			end
			op_movi: begin
				val = {{12{w[19]}}, w[19:0]};
				wr = 1'b1;
			end
			op_lwi: ld = 1'b1;
			op_swi: sto = 1'b1;
			op_ty_ls: begin
				sum = a + (b << w[9:8]);
				ld = (w[7:0] == ls_lw);
				sto = (w[7:0] == ls_sw);
			end
			default: wr = 1'b0;
		endcase
		if (ld) begin
			val = model_mem[sum[`CPU_DMEM_AW-1:0]];
			wr = 1'b1;
		end
		if (sto) begin
			st.valid = 1'b1;
			st.addr = sum[`CPU_DMEM_AW-1:0];
			st.data = model_regs[rt];
			model_mem[st.addr] = st.data;
		end
		if (wr && rt != 5'd0) begin
			model_regs[rt] = val;
			ret.valid = 1'b1;
			ret.addr = rt;
			ret.data = val;
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		assert (actual === expected) else begin
			error_count++;
			$display("ERROR %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// events only in the slot's memaccess and writeback cycles
	task automatic check_cycle(input int slot, input int ph, input retire_t er,
			input store_t es);
		string tag;
		tag = $sformatf("%s[%0d]", prog_name[slot], slot);
		check_value({tag, " retire.valid"}, 32'(ph == 4 && er.valid), 32'(retire.valid));
		check_value({tag, " store.valid"}, 32'(ph == 3 && es.valid), 32'(store.valid));
		if (ph == 4 && er.valid) begin
			check_value({tag, " retire.addr"}, 32'(er.addr), 32'(retire.addr));
			check_value({tag, " retire.data"}, er.data, retire.data);
		end
		if (ph == 3 && es.valid) begin
			check_value({tag, " store.addr"}, 32'(es.addr), 32'(store.addr));
			check_value({tag, " store.data"}, es.data, store.data);
		end
	endtask

	initial begin
		retire_t exp_ret;
		store_t  exp_st;
		int      slot;
		int      ph;
		int      failures;
		clock = 1'b0;
		reset = 1'b1;
		imem_load = '0;
		exp_ret = '0;
		exp_st = '0;
		void'($urandom(91));
		build_program();
		for (int r = 0; r < 32; r++) begin
			model_regs[r] = '0;
		end
		for (int m = 0; m < `CPU_DMEM_DEPTH; m++) begin
			model_mem[m] = '0;
		end
		// unused words stay opcode 0, which decodes as a nop
		for (int a = 0; a < `CPU_IMEM_DEPTH; a++) begin
			@(negedge clock);
			imem_load.we = 1'b1;
			imem_load.addr = a[`CPU_IMEM_AW-1:0];
			imem_load.data = (a < prog_len) ? prog[a] : 32'd0;
		end
		@(negedge clock);
		imem_load = '0;
		repeat (reset_cycles - `CPU_IMEM_DEPTH - 1) @(negedge clock);
		reset = 1'b0;
		// first fetch is the current cycle
		for (int j = 1; j < prog_len * 5; j++) begin
			@(negedge clock);
			slot = j / 5;
			ph = j % 5;
			if (ph == 3) begin
				model_step(prog[slot], exp_ret, exp_st);
			end
			check_cycle(slot, ph, exp_ret, exp_st);
		end
		failures = error_count + uut.u_asserts.fail_count;
		$display("checks %0d, value errors %0d, assertion failures %0d",
			check_count, error_count, uut.u_asserts.fail_count);
		if (failures == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		#(watchdog_cycles * clock_period);
		$display("watchdog expired, the program did not complete in time");
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+design
design/isa_pkg.sv
design/ctrl_pkg.sv
design/controller.sv
design/fetch_unit.sv
design/register_file.sv
design/execute_unit.sv
design/data_mem.sv
design/cpu_top.sv
sim/cpu_asserts.sv
sim/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f vlog.f -o cpu_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/cpu_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" sim.log; then
	exit 1
fi
exit 0
